//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_usb_rx
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Checks failed
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; \
	else echo "simulation passed"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_usb_rx.sv
// usb receiver testbench
`timescale 1ns/10ps

module tb_usb_rx;

  localparam logic [31:0] SEED = 32'h6bd1_f834;
  localparam int NUM_ROWS     = 17;
  localparam int SETTLE_LIMIT = 400;   // clocks allowed to return to idle
  localparam int BIT_MILLI    = 8333;  // clocks per bit times 1000, 83.33 ns

  // row faults
  localparam int F_NONE      = 0;
  localparam int F_BAD_CRC   = 1;  // crc5 field forced to zero
  localparam int F_CORRUPT   = 2;  // payload flipped after crc16
  localparam int F_BAD_SYNC  = 3;
  localparam int F_SHORT_EOP = 4;  // se0 four bits into the pid

  // pid classes
  localparam int CLS_NONE  = 0;
  localparam int CLS_TOKEN = 1;
  localparam int CLS_DATA  = 2;
  localparam int CLS_HAND  = 3;

  typedef struct {
    logic [7:0] pid;   // full pid byte, nibble and complement
    logic [6:0] addr;
    logic [3:0] endp;
    int         len;   // payload bytes
    logic [7:0] fill;  // fixed payload byte, 0 means random
    int         fault;
  } row_t;

  logic                   tb_clk;
  logic                   rst_n;
  logic                   d_plus;
  logic                   d_minus;
  usb_rx_pkg::rx_result_e rx_packet;
  logic                   rx_data_store;
  logic [7:0]             rx_data;

  row_t rows [NUM_ROWS];
  logic bits_q[$];   // unstuffed packet bits, msb first
  int   bit_index;   // bit position in the packet, for the bit grid
  logic line_lvl;    // 1 is J
  int   timeouts;

  always #5 tb_clk = ~tb_clk;

  usb_rx dut_i (
    .tb_clk(tb_clk), .rst_n(rst_n),
    .d_plus(d_plus), .d_minus(d_minus),
    .rx_packet(rx_packet), .rx_data_store(rx_data_store), .rx_data(rx_data)
  );

  usb_rx_checker chk_i (
    .tb_clk(tb_clk), .rst_n(rst_n),
    .rx_packet(rx_packet), .rx_data_store(rx_data_store), .rx_data(rx_data)
  );

  // **************************************************
  // stimulus table
  // **************************************************
  task automatic set_row(input int idx, input logic [7:0] pid, input logic [6:0] addr,
                         input logic [3:0] endp, input int len, input logic [7:0] fill,
                         input int fault);
    rows[idx].pid   = pid;
    rows[idx].addr  = addr;
    rows[idx].endp  = endp;
    rows[idx].len   = len;
    rows[idx].fill  = fill;
    rows[idx].fault = fault;
  endtask

  task automatic load_table();
    set_row(0,  8'h96, 7'd0, 4'd0, 0, 8'h00, F_NONE);       // IN
    set_row(1,  8'h1E, 7'd0, 4'd0, 0, 8'h00, F_NONE);       // OUT
    set_row(2,  8'h2D, 7'd0, 4'd0, 0, 8'h00, F_NONE);       // ACK
    set_row(3,  8'hA5, 7'd0, 4'd0, 0, 8'h00, F_NONE);       // NAK
    set_row(4,  8'h3C, 7'd0, 4'd0, 1, 8'h00, F_NONE);       // DATA0
    set_row(5,  8'hB4, 7'd0, 4'd0, 4, 8'h00, F_NONE);       // DATA1
    set_row(6,  8'h3C, 7'd0, 4'd0, 3, 8'h00, F_NONE);
    set_row(7,  8'h96, 7'd0, 4'd0, 0, 8'h00, F_BAD_CRC);
    set_row(8,  8'hB4, 7'd0, 4'd0, 2, 8'h00, F_CORRUPT);
    set_row(9,  8'h1E, 7'd5, 4'd0, 0, 8'h00, F_NONE);       // other device
    set_row(10, 8'h96, 7'd0, 4'd3, 0, 8'h00, F_NONE);       // other endpoint
    set_row(11, 8'h2D, 7'd0, 4'd0, 0, 8'h00, F_BAD_SYNC);
    set_row(12, 8'h99, 7'd0, 4'd0, 0, 8'h00, F_NONE);       // complement broken
    set_row(13, 8'h2D, 7'd0, 4'd0, 0, 8'h00, F_SHORT_EOP);
    set_row(14, 8'h3C, 7'd0, 4'd0, 4, 8'hFF, F_NONE);       // long ones runs
    set_row(15, 8'hB4, 7'd0, 4'd0, 3, 8'h3F, F_NONE);
    set_row(16, 8'h1E, 7'd0, 4'd0, 0, 8'h00, F_NONE);
  endtask

  // **************************************************
  // packet model
  // **************************************************
  function automatic int pid_class(input logic [7:0] pid);
    if (pid[3:0] != ~pid[7:4]) return CLS_NONE;
    case (pid[7:4])
      usb_rx_pkg::PID_OUT, usb_rx_pkg::PID_IN:     return CLS_TOKEN;
      usb_rx_pkg::PID_DATA0, usb_rx_pkg::PID_DATA1: return CLS_DATA;
      usb_rx_pkg::PID_ACK, usb_rx_pkg::PID_NAK:     return CLS_HAND;
      default:                                      return CLS_NONE;
    endcase
  endfunction

  // serial lfsr, preset ones, field sent inverted
  function automatic logic [4:0] calc_crc5(input logic [10:0] fields);
    logic [4:0] crc;
    logic       fb;
    crc = '1;
    for (int i = 10; i >= 0; i--) begin
      fb  = fields[i] ^ crc[4];
      crc = {crc[3:0], 1'b0};
      if (fb) crc = crc ^ 5'b00101;
    end
    return ~crc;
  endfunction

  function automatic logic [15:0] calc_crc16(input logic [7:0] data[$]);
    logic [15:0] crc;
    logic        fb;
    crc = '1;
    foreach (data[k]) begin
      for (int i = 7; i >= 0; i--) begin
        fb  = data[k][i] ^ crc[15];
        crc = {crc[14:0], 1'b0};
        if (fb) crc = crc ^ 16'h8005;
      end
    end
    return ~crc;
  endfunction

  task automatic push_bits(input logic [15:0] value, input int n);
    for (int i = n - 1; i >= 0; i--) bits_q.push_back(value[i]);  // msb first
  endtask

  // **************************************************
  // line driver
  // **************************************************
  // bit lengths of 8 or 9 clocks average out to 83.33 ns
  task automatic drive_line(input logic dp, input logic dm);
    int n;
    n = ((bit_index + 1) * BIT_MILLI) / 1000 - (bit_index * BIT_MILLI) / 1000;
    d_plus  = dp;
    d_minus = dm;
    bit_index++;
    repeat (n) @(posedge tb_clk);
    #1;
  endtask

  task automatic send_packet();
    int ones;
    ones      = 0;
    bit_index = 0;
    @(posedge tb_clk);
    #1;
    foreach (bits_q[i]) begin
      if (!bits_q[i]) line_lvl = !line_lvl;  // nrzi, zero toggles
      drive_line(line_lvl, !line_lvl);
      ones = bits_q[i] ? ones + 1 : 0;
      if (ones == 6) begin
        line_lvl = !line_lvl;  // stuffed zero
        drive_line(line_lvl, !line_lvl);
        ones = 0;
      end
    end
    drive_line(1'b0, 1'b0);  // se0, two bits
    drive_line(1'b0, 1'b0);
    line_lvl = 1'b1;
    repeat (4) drive_line(1'b1, 1'b0);  // J, then idle gap
  endtask

  // waits for the receiver to be back in idle
  task automatic wait_receiver_idle(input int idx);
    int n;
    n = 0;
    while (!(dut_i.u_line_decoder.line_idle &&
             dut_i.u_rx_control.state == usb_rx_pkg::ST_SYNC) && n < SETTLE_LIMIT) begin
      @(posedge tb_clk);
      n++;
    end
    if (n >= SETTLE_LIMIT) begin
      $display("TIMEOUT at %0t: row %0d, receiver never returned to idle", $time, idx);
      timeouts++;
    end
    @(posedge tb_clk);
    #1;
  endtask

  // **************************************************
  // one table row: build, predict, send, compare
  // **************************************************
  task automatic run_row(input int idx);
    row_t        r;
    logic [7:0]  payload[$];
    logic [4:0]  crc5_good;
    logic [4:0]  crc5_field;
    logic [15:0] crc16_val;
    int          cls;
    r   = rows[idx];
    cls = pid_class(r.pid);
    bits_q.delete();
    push_bits({8'h00, (r.fault == F_BAD_SYNC) ? 8'h11 : usb_rx_pkg::SYNC_BYTE}, 8);
    if (r.fault == F_SHORT_EOP) begin
      push_bits({12'h000, r.pid[7:4]}, 4);  // cut inside the pid
      chk_i.add_expected_result(usb_rx_pkg::RES_BAD);
    end else begin
      push_bits({8'h00, r.pid}, 8);
      if (cls == CLS_TOKEN) begin
        crc5_good  = calc_crc5({r.addr, r.endp});
        crc5_field = (r.fault == F_BAD_CRC) ? 5'd0 : crc5_good;
        push_bits({r.addr, r.endp, crc5_field}, 16);
        if (r.fault != F_BAD_SYNC && r.addr == usb_rx_pkg::DEV_ADDR &&
            r.endp == usb_rx_pkg::DEV_ENDP) begin
          if (crc5_field != crc5_good) chk_i.add_expected_result(usb_rx_pkg::RES_BAD);
          else if (r.pid[7:4] == usb_rx_pkg::PID_IN) chk_i.add_expected_result(usb_rx_pkg::RES_IN);
          else chk_i.add_expected_result(usb_rx_pkg::RES_OUT);
        end
      end else if (cls == CLS_DATA) begin
        for (int k = 0; k < r.len; k++) begin
          payload.push_back((r.fill != 8'h00) ? r.fill : 8'($urandom));
        end
        crc16_val = calc_crc16(payload);
        if (r.fault == F_CORRUPT) payload[0] = payload[0] ^ 8'h10;  // after crc
        foreach (payload[k]) push_bits({8'h00, payload[k]}, 8);
        push_bits(crc16_val, 16);
        if (r.fault != F_BAD_SYNC) begin
          chk_i.add_expected_result(usb_rx_pkg::RES_DATA);
          foreach (payload[k]) chk_i.add_expected_byte(payload[k]);
          if (r.fault == F_CORRUPT) chk_i.add_expected_result(usb_rx_pkg::RES_BAD);
        end
      end else if (cls == CLS_HAND && r.fault != F_BAD_SYNC) begin
        if (r.pid[7:4] == usb_rx_pkg::PID_ACK) chk_i.add_expected_result(usb_rx_pkg::RES_ACK);
        else chk_i.add_expected_result(usb_rx_pkg::RES_NAK);
      end
    end
    send_packet();
    wait_receiver_idle(idx);
    chk_i.compare_records(idx);
  endtask

  initial begin
    void'($urandom(SEED));
    tb_clk    = 1'b0;
    rst_n     = 1'b0;
    d_plus    = 1'b1;  // idle J
    d_minus   = 1'b0;
    line_lvl  = 1'b1;
    bit_index = 0;
    timeouts  = 0;
    load_table();
    repeat (3) @(posedge tb_clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge tb_clk);
    for (int i = 0; i < NUM_ROWS; i++) run_row(i);
    chk_i.report_counts(timeouts, dut_i.asrt_i.fail_count);
    if (chk_i.error_count == 0 && timeouts == 0 && dut_i.asrt_i.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- dv/usb_rx_assertions.sv
// receiver output protocol checks
`timescale 1ns/10ps

module usb_rx_assertions (
  input logic                   tb_clk,
  input logic                   rst_n,
  input logic                   eop,
  input logic                   rx_data_store,
  input usb_rx_pkg::rx_result_e rx_packet,
  input usb_rx_pkg::rx_state_e  state
);

  int fail_count;  // failed assertions so far

  initial fail_count = 0;

  // outputs quiet while in reset
  reset_quiet: assert property (@(posedge tb_clk)
    !rst_n |-> (rx_packet == usb_rx_pkg::RES_IDLE && !rx_data_store))
    else begin
      $error("receiver output active during reset");
      fail_count++;
    end

  store_single: assert property (@(posedge tb_clk) disable iff (!rst_n)
    rx_data_store |=> !rx_data_store)
    else begin
      $error("rx_data_store held for two cycles");
      fail_count++;
    end

  // silent eop only from discard, runt or an already reported data packet
  eop_result: assert property (@(posedge tb_clk) disable iff (!rst_n)
    eop && !(state inside {usb_rx_pkg::ST_DISCARD, usb_rx_pkg::ST_SYNC,
                           usb_rx_pkg::ST_PAYLOAD}) |=> rx_packet != usb_rx_pkg::RES_IDLE)
    else begin
      $error("eop without a result outside the discard state");
      fail_count++;
    end

endmodule

bind usb_rx usb_rx_assertions asrt_i (
  .tb_clk(tb_clk), .rst_n(rst_n), .eop(eop), .rx_data_store(rx_data_store),
  .rx_packet(rx_packet), .state(u_rx_control.state)
);

//--- dv/usb_rx_checker.sv
// usb receiver output monitor
`timescale 1ns/10ps

module usb_rx_checker (
  input logic                   tb_clk,
  input logic                   rst_n,
  input usb_rx_pkg::rx_result_e rx_packet,
  input logic                   rx_data_store,
  input logic [7:0]             rx_data
);

  usb_rx_pkg::rx_result_e got_res[$];
  usb_rx_pkg::rx_result_e exp_res[$];
  logic [7:0]             got_bytes[$];
  logic [7:0]             exp_bytes[$];
  int                     error_count;

  initial error_count = 0;

  // outputs are stable half a cycle after the edge
  always @(negedge tb_clk) begin
    if (rst_n) begin
      if (rx_packet != usb_rx_pkg::RES_IDLE) got_res.push_back(rx_packet);
      if (rx_data_store) got_bytes.push_back(rx_data);
    end
  end

  task automatic add_expected_result(input usb_rx_pkg::rx_result_e res);
    exp_res.push_back(res);
  endtask

  task automatic add_expected_byte(input logic [7:0] b);
    exp_bytes.push_back(b);
  endtask

  // **************************************************
  // per-row compare, then start over
  // **************************************************
  task automatic compare_records(input int row);
    if (got_res.size() != exp_res.size()) begin
      $display("row %0d: expected %0d results but received %0d",
               row, exp_res.size(), got_res.size());
      error_count++;
    end
    for (int i = 0; i < got_res.size() && i < exp_res.size(); i++) begin
      if (got_res[i] != exp_res[i]) begin
        $display("FAILED at %0t: rx_packet expected %s got %s (row %0d)",
                 $time, exp_res[i].name(), got_res[i].name(), row);
        error_count++;
      end
    end
    if (got_bytes.size() != exp_bytes.size()) begin
      $display("row %0d: expected %0d payload bytes but received %0d",
               row, exp_bytes.size(), got_bytes.size());
      error_count++;
    end
    for (int i = 0; i < got_bytes.size() && i < exp_bytes.size(); i++) begin
      if (got_bytes[i] != exp_bytes[i]) begin
        $display("FAILED at %0t: rx_data expected 0x%02h got 0x%02h (row %0d, byte %0d)",
                 $time, exp_bytes[i], got_bytes[i], row, i);
        error_count++;
      end
    end
    got_res.delete();
    exp_res.delete();
    got_bytes.delete();
    exp_bytes.delete();
  endtask

  task automatic report_counts(input int timeouts, input int assert_fails);
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             error_count, timeouts, assert_fails);
  endtask

endmodule

//--- source/usb_bit_timer.sv
// usb bit timer
`timescale 1ns/10ps

module usb_bit_timer (
  input  logic tb_clk,
  input  logic rst_n,
  input  logic line_edge,   // synchronized transition on the pair
  input  logic line_idle,   // no packet on the line
  output logic bit_sample   // one cycle strobe at mid-bit
);

  logic [3:0] clk_cnt;  // clocks since the last edge or bit boundary

  // restart on every transition so timing follows the sender
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      clk_cnt <= '0;
    end else if (line_idle || line_edge) begin
      clk_cnt <= '0;  // hold while idle, re-align on edges
    end else if (clk_cnt == usb_rx_pkg::CLKS_PER_BIT - 4'd1) begin
      clk_cnt <= '0;  // next bit, no edge seen
    end else begin
      clk_cnt <= clk_cnt + 4'd1;
    end
  end

  // sample point sits half a bit after the boundary
  assign bit_sample = !line_idle && (clk_cnt == usb_rx_pkg::SAMPLE_POINT);

endmodule

//--- source/usb_byte_shifter.sv
// usb byte shifter
`timescale 1ns/10ps

module usb_byte_shifter (
  input  logic                          tb_clk,
  input  logic                          rst_n,
  input  logic                          bit_valid,
  input  logic                          bit_data,
  input  logic                          frame_clr,
  input  logic                          eop,
  output logic                          byte_valid,
  output logic [usb_rx_pkg::BYTE_W-1:0] byte_data,
  output logic                          partial
);

  logic [2:0] bit_cnt;  // bits already in the current byte

  // msb arrives first and ends up on top
  always_ff @(posedge tb_clk) begin
    if (bit_valid) byte_data <= {byte_data[usb_rx_pkg::BYTE_W-2:0], bit_data};
  end

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (frame_clr) begin
        bit_cnt <= '0;  // new frame
      end else if (bit_valid) begin
        bit_cnt <= bit_cnt + 3'd1;  // wraps after eight
        if (bit_cnt == 3'd7) byte_valid <= 1'b1;
      end
    end
  end

  // eop landing between byte boundaries
  assign partial = eop && (bit_cnt != 3'd0);

endmodule

//--- source/usb_crc_checker.sv
// usb crc checker
`timescale 1ns/10ps

module usb_crc_checker (
  input  logic tb_clk,
  input  logic rst_n,
  input  logic bit_valid,
  input  logic bit_data,
  input  logic crc_en,
  input  logic frame_clr,
  output logic crc5_ok,
  output logic crc16_ok
);

  logic [4:0]  crc5;
  logic [15:0] crc16;
  logic        fb5;   // feedback taps
  logic        fb16;

  assign fb5  = bit_data ^ crc5[4];
  assign fb16 = bit_data ^ crc16[15];

  // **************************************************
  // token crc5
  // **************************************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      crc5 <= '1;
    end else if (frame_clr) begin
      crc5 <= '1;  // preset
    end else if (bit_valid && crc_en) begin
      crc5 <= {crc5[3:0], 1'b0} ^ (fb5 ? usb_rx_pkg::CRC5_POLY : 5'd0);
    end
  end

  // **************************************************
  // data crc16
  // **************************************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      crc16 <= '1;
    end else if (frame_clr) begin
      crc16 <= '1;
    end else if (bit_valid && crc_en) begin
      crc16 <= {crc16[14:0], 1'b0} ^ (fb16 ? usb_rx_pkg::CRC16_POLY : 16'd0);
    end
  end

  // good frame leaves the fixed residue, control picks the one it needs
  assign crc5_ok  = (crc5 == usb_rx_pkg::CRC5_RESIDUE);
  assign crc16_ok = (crc16 == usb_rx_pkg::CRC16_RESIDUE);

endmodule

//--- source/usb_data_holdback.sv
// usb payload holdback
`timescale 1ns/10ps

module usb_data_holdback (
  input  logic                          tb_clk,
  input  logic                          rst_n,
  input  logic                          byte_valid,
  input  logic                          hold_en,
  input  logic                          frame_clr,
  input  logic [usb_rx_pkg::BYTE_W-1:0] byte_data,
  output logic                          rx_data_store,
  output logic [usb_rx_pkg::BYTE_W-1:0] rx_data
);

  logic [usb_rx_pkg::BYTE_W-1:0] hold_new;  // most recent byte
  logic [usb_rx_pkg::BYTE_W-1:0] hold_old;  // byte before it
  logic [1:0]                    fill;      // 0..2 bytes held
  logic                          push;

  assign push = byte_valid && hold_en;

  // last two bytes of a data packet are the crc16, they stay behind
  always_ff @(posedge tb_clk) begin
    if (push) begin
      hold_old <= hold_new;
      hold_new <= byte_data;
      if (fill == 2'd2) rx_data <= hold_old;  // oldest leaves
    end
  end

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      fill          <= '0;
      rx_data_store <= 1'b0;
    end else begin
      rx_data_store <= push && (fill == 2'd2);  // one cycle strobe
      if (frame_clr) begin
        fill <= '0;
      end else if (push && fill != 2'd2) begin
        fill <= fill + 2'd1;
      end
    end
  end

endmodule

//--- source/usb_line_decoder.sv
// usb line decoder
`timescale 1ns/10ps

module usb_line_decoder (
  input  logic tb_clk,
  input  logic rst_n,
  input  logic d_plus,
  input  logic d_minus,
  input  logic bit_sample,
  output logic line_edge,
  output logic line_idle,
  output logic bit_valid,
  output logic bit_data,
  output logic eop
);

  logic [1:0] dp_sync;   // [1] is the synchronized level
  logic [1:0] dm_sync;
  logic       dp_q;      // previous synchronized levels, for edges
  logic       dm_q;
  logic       se0;
  logic       nrzi_bit;
  logic       prev_lvl;  // d_plus at the last sample
  logic [2:0] ones_cnt;  // run of decoded ones
  logic       se0_seen;

  // **************************************************
  // synchronizers and edge detect
  // **************************************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      dp_sync <= 2'b11;  // line rests in J
      dm_sync <= 2'b00;
      dp_q    <= 1'b1;
      dm_q    <= 1'b0;
    end else begin
      dp_sync <= {dp_sync[0], d_plus};
      dm_sync <= {dm_sync[0], d_minus};
      dp_q    <= dp_sync[1];
      dm_q    <= dm_sync[1];
    end
  end

  assign line_edge = (dp_sync[1] != dp_q) || (dm_sync[1] != dm_q);
  assign se0       = !dp_sync[1] && !dm_sync[1];  // both low
  assign nrzi_bit  = (dp_sync[1] == prev_lvl);    // no change is a one

  // **************************************************
  // nrzi decode, unstuff, eop
  // **************************************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      line_idle <= 1'b1;
      prev_lvl  <= 1'b1;
      ones_cnt  <= '0;
      se0_seen  <= 1'b0;
      bit_valid <= 1'b0;
      bit_data  <= 1'b0;
      eop       <= 1'b0;
    end else begin
      bit_valid <= 1'b0;
      eop       <= 1'b0;
      if (line_edge) line_idle <= 1'b0;  // packet starts on first transition
      if (bit_sample) begin
        if (se0) begin
          se0_seen <= 1'b1;
        end else if (se0_seen) begin
          // J after se0 closes the packet
          se0_seen  <= 1'b0;
          eop       <= 1'b1;
          line_idle <= 1'b1;
          prev_lvl  <= 1'b1;
          ones_cnt  <= '0;
        end else begin
          prev_lvl <= dp_sync[1];
          if (ones_cnt == usb_rx_pkg::STUFF_RUN) begin
            ones_cnt <= '0;  // stuffed bit, dropped
          end else begin
            bit_valid <= 1'b1;
            bit_data  <= nrzi_bit;
            ones_cnt  <= nrzi_bit ? ones_cnt + 3'd1 : 3'd0;
          end
        end
      end
    end
  end

endmodule

//--- source/usb_rx.sv
// usb full-speed receiver
`timescale 1ns/10ps

module usb_rx (
  input  logic                          tb_clk,
  input  logic                          rst_n,
  input  logic                          d_plus,
  input  logic                          d_minus,
  output usb_rx_pkg::rx_result_e        rx_packet,
  output logic                          rx_data_store,
  output logic [usb_rx_pkg::BYTE_W-1:0] rx_data
);

  // line side
  logic bit_sample;
  logic line_edge;
  logic line_idle;
  logic bit_valid;
  logic bit_data;
  logic eop;

  // byte side
  logic                          byte_valid;
  logic [usb_rx_pkg::BYTE_W-1:0] byte_data;
  logic                          partial;
  logic                          crc5_ok;
  logic                          crc16_ok;
  logic                          frame_clr;
  logic                          crc_en;
  logic                          hold_en;

  // **************************************************
  // bit recovery
  // **************************************************
  usb_bit_timer u_bit_timer (
    .tb_clk(tb_clk), .rst_n(rst_n),
    .line_edge(line_edge), .line_idle(line_idle),
    .bit_sample(bit_sample)
  );

  usb_line_decoder u_line_decoder (
    .tb_clk(tb_clk), .rst_n(rst_n),
    .d_plus(d_plus), .d_minus(d_minus), .bit_sample(bit_sample),
    .line_edge(line_edge), .line_idle(line_idle),
    .bit_valid(bit_valid), .bit_data(bit_data), .eop(eop)
  );

  // **************************************************
  // framing and checks
  // **************************************************
  usb_byte_shifter u_byte_shifter (
    .tb_clk(tb_clk), .rst_n(rst_n),
    .bit_valid(bit_valid), .bit_data(bit_data), .frame_clr(frame_clr), .eop(eop),
    .byte_valid(byte_valid), .byte_data(byte_data), .partial(partial)
  );

  usb_crc_checker u_crc_checker (
    .tb_clk(tb_clk), .rst_n(rst_n),
    .bit_valid(bit_valid), .bit_data(bit_data), .crc_en(crc_en), .frame_clr(frame_clr),
    .crc5_ok(crc5_ok), .crc16_ok(crc16_ok)
  );

  usb_data_holdback u_data_holdback (
    .tb_clk(tb_clk), .rst_n(rst_n),
    .byte_valid(byte_valid), .hold_en(hold_en), .frame_clr(frame_clr),
    .byte_data(byte_data),
    .rx_data_store(rx_data_store), .rx_data(rx_data)
  );

  usb_rx_control u_rx_control (
    .tb_clk(tb_clk), .rst_n(rst_n),
    .byte_valid(byte_valid), .byte_data(byte_data), .eop(eop), .partial(partial),
    .crc5_ok(crc5_ok), .crc16_ok(crc16_ok),
    .frame_clr(frame_clr), .crc_en(crc_en), .hold_en(hold_en),
    .rx_packet(rx_packet)
  );

endmodule

//--- source/usb_rx_control.sv
// usb packet control
`timescale 1ns/10ps

module usb_rx_control (
  input  logic                          tb_clk,
  input  logic                          rst_n,
  input  logic                          byte_valid,
  input  logic [usb_rx_pkg::BYTE_W-1:0] byte_data,
  input  logic                          eop,
  input  logic                          partial,
  input  logic                          crc5_ok,
  input  logic                          crc16_ok,
  output logic                          frame_clr,
  output logic                          crc_en,
  output logic                          hold_en,
  output usb_rx_pkg::rx_result_e        rx_packet
);

  usb_rx_pkg::rx_state_e state;
  usb_rx_pkg::pid_e      pid_in;    // pid nibble of the current byte
  usb_rx_pkg::pid_e      pid_q;     // pid of this packet
  logic                  pid_ok;    // nibble matches its complement
  logic                  addr_ok;
  logic                  endp_msb;  // endp[3] rides in the first token byte
  logic                  endp_ok;

  assign pid_in  = usb_rx_pkg::pid_e'(byte_data[7:4]);
  assign pid_ok  = (byte_data[3:0] == ~byte_data[7:4]);
  assign endp_ok = ({endp_msb, byte_data[7:5]} == usb_rx_pkg::DEV_ENDP);

  assign frame_clr = (state == usb_rx_pkg::ST_IDLE);
  assign crc_en    = (state == usb_rx_pkg::ST_TOKEN1) || (state == usb_rx_pkg::ST_TOKEN2) ||
                     (state == usb_rx_pkg::ST_PAYLOAD);  // everything after the pid
  assign hold_en   = (state == usb_rx_pkg::ST_PAYLOAD);

  // packet fields
  always_ff @(posedge tb_clk) begin
    if (byte_valid && state == usb_rx_pkg::ST_PID) pid_q <= pid_in;
    if (byte_valid && state == usb_rx_pkg::ST_TOKEN1) begin
      addr_ok  <= (byte_data[7:1] == usb_rx_pkg::DEV_ADDR);
      endp_msb <= byte_data[0];
    end
  end

  // **************************************************
  // packet fsm, results strobe for one cycle
  // **************************************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= usb_rx_pkg::ST_IDLE;
      rx_packet <= usb_rx_pkg::RES_IDLE;
    end else begin
      rx_packet <= usb_rx_pkg::RES_IDLE;
      case (state)
        usb_rx_pkg::ST_IDLE: state <= usb_rx_pkg::ST_SYNC;
        usb_rx_pkg::ST_SYNC: begin
          if (eop) state <= usb_rx_pkg::ST_IDLE;  // runt, nothing to report
          else if (byte_valid) state <= (byte_data == usb_rx_pkg::SYNC_BYTE) ?
                                        usb_rx_pkg::ST_PID : usb_rx_pkg::ST_DISCARD;
        end
        usb_rx_pkg::ST_PID: begin
          if (eop) begin
            rx_packet <= usb_rx_pkg::RES_BAD;  // cut short
            state     <= usb_rx_pkg::ST_IDLE;
          end else if (byte_valid) begin
            if (!pid_ok) begin
              state <= usb_rx_pkg::ST_DISCARD;
            end else begin
              case (pid_in)
                usb_rx_pkg::PID_OUT, usb_rx_pkg::PID_IN: state <= usb_rx_pkg::ST_TOKEN1;
                usb_rx_pkg::PID_DATA0, usb_rx_pkg::PID_DATA1: begin
                  state     <= usb_rx_pkg::ST_PAYLOAD;
                  rx_packet <= usb_rx_pkg::RES_DATA;  // announced before payload
                end
                usb_rx_pkg::PID_ACK, usb_rx_pkg::PID_NAK: state <= usb_rx_pkg::ST_HANDSHAKE_END;
                default: state <= usb_rx_pkg::ST_DISCARD;  // unsupported pid
              endcase
            end
          end
        end
        usb_rx_pkg::ST_TOKEN1, usb_rx_pkg::ST_TOKEN2: begin
          if (eop) begin
            rx_packet <= usb_rx_pkg::RES_BAD;
            state     <= usb_rx_pkg::ST_IDLE;
          end else if (byte_valid && state == usb_rx_pkg::ST_TOKEN1) begin
            state <= usb_rx_pkg::ST_TOKEN2;
          end else if (byte_valid) begin
            // another device's token, stay silent
            state <= (addr_ok && endp_ok) ? usb_rx_pkg::ST_TOKEN_END : usb_rx_pkg::ST_DISCARD;
          end
        end
        usb_rx_pkg::ST_TOKEN_END: begin
          if (eop) begin
            if (partial || !crc5_ok) rx_packet <= usb_rx_pkg::RES_BAD;
            else if (pid_q == usb_rx_pkg::PID_IN) rx_packet <= usb_rx_pkg::RES_IN;
            else rx_packet <= usb_rx_pkg::RES_OUT;
            state <= usb_rx_pkg::ST_IDLE;
          end else if (byte_valid) begin
            state <= usb_rx_pkg::ST_DISCARD;  // token too long
          end
        end
        usb_rx_pkg::ST_PAYLOAD: begin
          if (eop) begin
            if (partial || !crc16_ok) rx_packet <= usb_rx_pkg::RES_BAD;  // after the bytes
            state <= usb_rx_pkg::ST_IDLE;
          end
        end
        usb_rx_pkg::ST_HANDSHAKE_END: begin
          if (eop) begin
            if (partial) rx_packet <= usb_rx_pkg::RES_BAD;
            else if (pid_q == usb_rx_pkg::PID_ACK) rx_packet <= usb_rx_pkg::RES_ACK;
            else rx_packet <= usb_rx_pkg::RES_NAK;
            state <= usb_rx_pkg::ST_IDLE;
          end else if (byte_valid) begin
            state <= usb_rx_pkg::ST_DISCARD;
          end
        end
        usb_rx_pkg::ST_DISCARD: if (eop) state <= usb_rx_pkg::ST_IDLE;
        default: state <= usb_rx_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

//--- source/usb_rx_pkg.sv
// usb receive definitions
package usb_rx_pkg;

  // **************************************************
  // line timing and bit recovery
  // **************************************************
  localparam logic [3:0] CLKS_PER_BIT = 4'd8;  // 100 MHz over 12 Mbit, rounded
  localparam logic [3:0] SAMPLE_POINT = 4'd4;  // mid-bit, counted from an edge
  localparam logic [2:0] STUFF_RUN    = 3'd6;  // ones before a stuffed bit

  localparam int BYTE_W = 8;

  localparam logic [BYTE_W-1:0] SYNC_BYTE = 8'h01;  // seven zeros then a one

  // device identity, tokens for anything else are ignored
  localparam logic [6:0] DEV_ADDR = 7'd0;
  localparam logic [3:0] DEV_ENDP = 4'd0;

  // **************************************************
  // crc generators, preset all ones
  // **************************************************
  // residue is what is left once the inverted crc went through the lfsr
  localparam logic [4:0]  CRC5_POLY     = 5'b00101;
  localparam logic [4:0]  CRC5_RESIDUE  = 5'b01100;
  localparam logic [15:0] CRC16_POLY    = 16'h8005;
  localparam logic [15:0] CRC16_RESIDUE = 16'h800D;

  // upper nibble of the pid byte, lower nibble is its complement
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010
  } pid_e;

  // what rx_packet reports, idle between strobes
  typedef enum logic [2:0] {
    RES_IDLE = 3'd0,
    RES_DATA = 3'd1,
    RES_OUT  = 3'd2,
    RES_IN   = 3'd3,
    RES_ACK  = 3'd4,
    RES_NAK  = 3'd5,
    RES_BAD  = 3'd6
  } rx_result_e;

  typedef enum logic [3:0] {
    ST_IDLE,           // one cycle, clears the frame
    ST_SYNC,           // waiting for the first byte
    ST_PID,
    ST_TOKEN1,         // addr + endp msb
    ST_TOKEN2,         // endp low bits + crc5
    ST_TOKEN_END,
    ST_PAYLOAD,
    ST_HANDSHAKE_END,
    ST_DISCARD         // ignore the rest until eop
  } rx_state_e;

endpackage

//--- sources.f
source/usb_rx_pkg.sv
source/usb_bit_timer.sv
source/usb_line_decoder.sv
source/usb_byte_shifter.sv
source/usb_crc_checker.sv
source/usb_data_holdback.sv
source/usb_rx_control.sv
source/usb_rx.sv
dv/usb_rx_checker.sv
dv/usb_rx_assertions.sv
dv/tb_usb_rx.sv
